//--- logic/rob_cfg_pkg.sv
// buffer sizes, index and pointer types, default exception vector
package rob_cfg_pkg;

  // ================================================
  // sizes
  // ================================================
  // entries, keep a power of two so the pointers wrap on their own
  parameter int ROB_DEPTH   = 8;
  parameter int ALLOC_WIDTH = 2;
  parameter int CMT_WIDTH   = 2;

  parameter int IDX_W = $clog2(ROB_DEPTH);
  parameter int CNT_W = $clog2(ROB_DEPTH + 1);

  // ================================================
  // index types
  // ================================================
  typedef logic [IDX_W-1:0] rob_idx_t;
  // top bit is the wrap bit
  typedef logic [IDX_W:0]   rob_ptr_t;
  // 0 .. ROB_DEPTH
  typedef logic [CNT_W-1:0] rob_cnt_t;

  // fetch restarts here on any exception
  parameter logic [31:0] EXC_VECTOR_DEFAULT = 32'h1c00_0000;

endpackage

//--- logic/rob_entry_pkg.sv
// entry payload, writeback status and commit slot structs
package rob_entry_pkg;

  // ================================================
  // entry payload
  // ================================================
  // static part, written once by decode
  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  dest;
    logic        is_branch;
    logic        is_store;
  } rob_info_t;

  // ================================================
  // writeback status
  // ================================================
  // cleared at allocation, filled by the writeback ports
  typedef struct packed {
    logic        complete;
    // exception seen in decode or in the memory stage
    logic        excp;
    // branch mispredict, fetch restarts at target
    logic        redirect;
    logic [31:0] target;
    logic [31:0] result;
  } rob_status_t;

  // ================================================
  // commit slot
  // ================================================
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [4:0]  dest;
    logic [31:0] result;
  } rob_cmt_t;

endpackage

//--- logic/rob_head_if.sv
// head pointer, occupancy and commit control shared by the buffer blocks
`timescale 1ns/100ps

interface rob_head_if ();
  import rob_cfg_pkg::*;

  rob_ptr_t                   head;
  rob_cnt_t                   occupancy;
  // entries retired this cycle, 0 .. CMT_WIDTH
  logic [$clog2(CMT_WIDTH):0] commit_cnt;
  // empty the buffer at the end of the cycle
  logic                       clear;
  // refuse new allocations
  logic                       hold;

  modport ptr (output head, output occupancy,
               input commit_cnt, input clear, input hold);
  modport cmt (input occupancy,
               output commit_cnt, output clear, output hold);
  modport wb  (input head);
  modport rd  (input head);

endinterface

//--- logic/rob_ptr_ctrl.sv
// head and tail pointers, occupancy count and allocation handshake
`timescale 1ns/100ps

module rob_ptr_ctrl #(
  parameter int DEPTH = rob_cfg_pkg::ROB_DEPTH
) (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic [rob_cfg_pkg::ALLOC_WIDTH-1:0]               alloc_valid,
  output logic                                              alloc_ready,
  output rob_cfg_pkg::rob_ptr_t [rob_cfg_pkg::ALLOC_WIDTH-1:0] alloc_idx,
  rob_head_if.ptr                                           head_if
);
  import rob_cfg_pkg::*;

  rob_ptr_t head_q;
  rob_ptr_t tail_q;
  rob_cnt_t occ_q;
  // slots taken this cycle
  rob_cnt_t alloc_cnt;
  rob_cnt_t cmt_cnt;

  // room for a full decode group, and no flush in progress
  assign alloc_ready = !head_if.hold && (occ_q <= rob_cnt_t'(DEPTH - ALLOC_WIDTH));

  always_comb begin
    alloc_cnt = '0;
    if (alloc_ready) begin
      for (int i = 0; i < ALLOC_WIDTH; i++) begin
        alloc_cnt = alloc_cnt + rob_cnt_t'(alloc_valid[i]);
      end
    end
  end

  assign cmt_cnt = rob_cnt_t'(head_if.commit_cnt);

  // slot i lands i entries past the tail
  always_comb begin
    for (int i = 0; i < ALLOC_WIDTH; i++) begin
      alloc_idx[i] = tail_q + rob_ptr_t'(i);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q <= '0;
      tail_q <= '0;
      occ_q  <= '0;
    end else if (head_if.clear) begin
      head_q <= '0;
      tail_q <= '0;
      occ_q  <= '0;
    end else begin
      head_q <= head_q + rob_ptr_t'(cmt_cnt);
      tail_q <= tail_q + rob_ptr_t'(alloc_cnt);
      occ_q  <= occ_q + alloc_cnt - cmt_cnt;
    end
  end

  assign head_if.head      = head_q;
  assign head_if.occupancy = occ_q;

endmodule

//--- logic/rob_entry_ram.sv
// register-array entry storage, several write ports, head and head+1 reads
`timescale 1ns/100ps

module rob_entry_ram #(
  parameter int  DEPTH   = rob_cfg_pkg::ROB_DEPTH,
  parameter int  N_WR    = 2,
  parameter type entry_t = logic
) (
  input  logic                                 clk,
  input  logic [N_WR-1:0]                      wr_en,
  input  rob_cfg_pkg::rob_idx_t [N_WR-1:0]     wr_idx,
  input  entry_t [N_WR-1:0]                    wr_data,
  input  rob_cfg_pkg::rob_idx_t                rd_head,
  output entry_t [1:0]                         rd_data
);
  import rob_cfg_pkg::*;

  entry_t   mem [DEPTH];
  // entry behind the head, wraps at the last slot
  rob_idx_t rd_next;

  // ================================================
  // write ports
  // ================================================
  // later ports are assigned last, so the higher port number wins
  always_ff @(posedge clk) begin
    for (int w = 0; w < N_WR; w++) begin
      if (wr_en[w]) begin
        mem[wr_idx[w]] <= wr_data[w];
      end
    end
  end

  // ================================================
  // read ports
  // ================================================
  always_comb begin
    if (rd_head == rob_idx_t'(DEPTH - 1)) begin
      rd_next = '0;
    end else begin
      rd_next = rd_head + 1'b1;
    end
  end

  assign rd_data[0] = mem[rd_head];
  assign rd_data[1] = mem[rd_next];

endmodule

//--- logic/rob_wb_merge.sv
// allocation and writeback strobes mapped onto the status write ports
`timescale 1ns/100ps

module rob_wb_merge (
  input  logic [rob_cfg_pkg::ALLOC_WIDTH-1:0]                   alloc_valid,
  input  logic [rob_cfg_pkg::ALLOC_WIDTH-1:0]                   alloc_excp,
  input  logic                                                  alloc_ok,
  input  rob_cfg_pkg::rob_ptr_t [rob_cfg_pkg::ALLOC_WIDTH-1:0]  alloc_idx,
  input  logic [1:0]                                            alu_wb_valid,
  input  rob_cfg_pkg::rob_ptr_t [1:0]                           alu_wb_idx,
  input  logic [1:0][31:0]                                      alu_wb_result,
  input  logic [1:0]                                            alu_wb_redirect,
  input  logic [1:0][31:0]                                      alu_wb_target,
  input  logic                                                  mem_wb_valid,
  input  rob_cfg_pkg::rob_ptr_t                                 mem_wb_idx,
  input  logic [31:0]                                           mem_wb_result,
  input  logic                                                  mem_wb_excp,
  input  logic                                                  mem_wb_is_store,
  output logic                                                  mem_wb_ready,
  rob_head_if.wb                                                head_if,
  output logic [rob_cfg_pkg::ALLOC_WIDTH+2:0]                   st_wr_en,
  output rob_cfg_pkg::rob_idx_t [rob_cfg_pkg::ALLOC_WIDTH+2:0]  st_wr_idx,
  output rob_entry_pkg::rob_status_t [rob_cfg_pkg::ALLOC_WIDTH+2:0] st_wr_data
);
  import rob_cfg_pkg::*;

  // port map: allocation slots first, then the two ALUs, memory last
  localparam int ALU_PORT = ALLOC_WIDTH;
  localparam int MEM_PORT = ALLOC_WIDTH + 2;

  // stores only write back once they are the oldest entry
  assign mem_wb_ready = !mem_wb_is_store || (mem_wb_idx == head_if.head);

  always_comb begin
    st_wr_en   = '0;
    st_wr_idx  = '0;
    st_wr_data = '0;

    // fresh status, a decode exception counts as done
    for (int i = 0; i < ALLOC_WIDTH; i++) begin
      st_wr_en[i]            = alloc_valid[i] && alloc_ok;
      st_wr_idx[i]           = alloc_idx[i][IDX_W-1:0];
      st_wr_data[i].complete = alloc_excp[i];
      st_wr_data[i].excp     = alloc_excp[i];
    end

    // alu results, always accepted
    for (int a = 0; a < 2; a++) begin
      st_wr_en[ALU_PORT+a]            = alu_wb_valid[a];
      st_wr_idx[ALU_PORT+a]           = alu_wb_idx[a][IDX_W-1:0];
      st_wr_data[ALU_PORT+a].complete = 1'b1;
      st_wr_data[ALU_PORT+a].redirect = alu_wb_redirect[a];
      st_wr_data[ALU_PORT+a].target   = alu_wb_target[a];
      st_wr_data[ALU_PORT+a].result   = alu_wb_result[a];
    end

    // memory port, may raise an exception
    st_wr_en[MEM_PORT]            = mem_wb_valid && mem_wb_ready;
    st_wr_idx[MEM_PORT]           = mem_wb_idx[IDX_W-1:0];
    st_wr_data[MEM_PORT].complete = 1'b1;
    st_wr_data[MEM_PORT].excp     = mem_wb_excp;
    st_wr_data[MEM_PORT].result   = mem_wb_result;
  end

endmodule

//--- logic/rob_commit_fsm.sv
// in-order commit selection and the run/flush state machine
`timescale 1ns/100ps

module rob_commit_fsm #(
  parameter logic [31:0] EXC_VECTOR = rob_cfg_pkg::EXC_VECTOR_DEFAULT
) (
  input  logic                                                     clk,
  input  logic                                                     rst_n,
  input  rob_entry_pkg::rob_info_t [rob_cfg_pkg::CMT_WIDTH-1:0]    info,
  input  rob_entry_pkg::rob_status_t [rob_cfg_pkg::CMT_WIDTH-1:0]  status,
  rob_head_if.cmt                                                  head_if,
  output rob_entry_pkg::rob_cmt_t [rob_cfg_pkg::CMT_WIDTH-1:0]     cmt,
  output logic                                                     flush,
  output logic [31:0]                                              flush_target
);
  import rob_cfg_pkg::*;

  typedef enum logic {
    ST_RUN,
    ST_FLUSH
  } state_t;

  state_t                 state_q;
  logic [31:0]            target_q;
  logic [CMT_WIDTH-1:0]   cmt_ok;
  // entry ends the commit group and triggers a flush
  logic [CMT_WIDTH-1:0]   kill;

  // ================================================
  // commit selection
  // ================================================
  always_comb begin
    for (int i = 0; i < CMT_WIDTH; i++) begin
      kill[i] = status[i].excp || status[i].redirect;
    end

    cmt_ok[0] = (state_q == ST_RUN) &&
                (head_an_entry()) &&
                status[0].complete;

    // second slot only behind a plain, non-branch first slot
    cmt_ok[1] = cmt_ok[0] &&
                (head_if.occupancy >= rob_cnt_t'(2)) &&
                status[1].complete &&
                !info[0].is_branch &&
                !kill[0] &&
                !kill[1];
  end

  function automatic logic head_an_entry();
    return head_if.occupancy != '0;
  endfunction

  assign head_if.commit_cnt = {1'b0, cmt_ok[0]} + {1'b0, cmt_ok[1]};

  always_comb begin
    for (int i = 0; i < CMT_WIDTH; i++) begin
      cmt[i].valid  = cmt_ok[i];
      cmt[i].pc     = info[i].pc;
      cmt[i].dest   = info[i].dest;
      cmt[i].result = status[i].result;
    end
  end

  // ================================================
  // run / flush
  // ================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_RUN;
    end else if (state_q == ST_FLUSH) begin
      state_q <= ST_RUN;
    end else if (cmt_ok[0] && kill[0]) begin
      state_q <= ST_FLUSH;
    end
  end

  // exception wins over a redirect on the same entry
  always_ff @(posedge clk) begin
    if (cmt_ok[0] && kill[0]) begin
      target_q <= status[0].excp ? EXC_VECTOR : status[0].target;
    end
  end

  assign flush        = (state_q == ST_FLUSH);
  assign flush_target = target_q;
  assign head_if.hold  = flush;
  assign head_if.clear = flush;

endmodule

//--- logic/rob_top.sv
// reorder buffer top level, plain ports around pointer, RAM, merge and commit blocks
`timescale 1ns/100ps

module rob_top #(
  parameter int          DEPTH      = rob_cfg_pkg::ROB_DEPTH,
  parameter logic [31:0] EXC_VECTOR = rob_cfg_pkg::EXC_VECTOR_DEFAULT
) (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  logic [rob_cfg_pkg::ALLOC_WIDTH-1:0]                  alloc_valid,
  input  logic [rob_cfg_pkg::ALLOC_WIDTH-1:0][31:0]            alloc_pc,
  input  logic [rob_cfg_pkg::ALLOC_WIDTH-1:0][4:0]             alloc_dest,
  input  logic [rob_cfg_pkg::ALLOC_WIDTH-1:0]                  alloc_is_branch,
  input  logic [rob_cfg_pkg::ALLOC_WIDTH-1:0]                  alloc_is_store,
  input  logic [rob_cfg_pkg::ALLOC_WIDTH-1:0]                  alloc_excp,
  output logic                                                 alloc_ready,
  output rob_cfg_pkg::rob_ptr_t [rob_cfg_pkg::ALLOC_WIDTH-1:0] alloc_idx,
  input  logic [1:0]                                           alu_wb_valid,
  input  rob_cfg_pkg::rob_ptr_t [1:0]                          alu_wb_idx,
  input  logic [1:0][31:0]                                     alu_wb_result,
  input  logic [1:0]                                           alu_wb_redirect,
  input  logic [1:0][31:0]                                     alu_wb_target,
  input  logic                                                 mem_wb_valid,
  input  rob_cfg_pkg::rob_ptr_t                                mem_wb_idx,
  input  logic [31:0]                                          mem_wb_result,
  input  logic                                                 mem_wb_excp,
  input  logic                                                 mem_wb_is_store,
  output logic                                                 mem_wb_ready,
  output logic [rob_cfg_pkg::CMT_WIDTH-1:0]                    cmt_valid,
  output logic [rob_cfg_pkg::CMT_WIDTH-1:0][31:0]              cmt_pc,
  output logic [rob_cfg_pkg::CMT_WIDTH-1:0][4:0]               cmt_dest,
  output logic [rob_cfg_pkg::CMT_WIDTH-1:0][31:0]              cmt_result,
  output logic                                                 flush,
  output logic [31:0]                                          flush_target
);
  import rob_cfg_pkg::*;
  import rob_entry_pkg::*;

  localparam int N_ST = ALLOC_WIDTH + 3;

  rob_head_if head_if ();

  logic [ALLOC_WIDTH-1:0]                info_wr_en;
  rob_idx_t [ALLOC_WIDTH-1:0]            info_wr_idx;
  rob_info_t [ALLOC_WIDTH-1:0]           info_wr_data;
  rob_info_t [CMT_WIDTH-1:0]             info_rd;
  logic [N_ST-1:0]                       st_wr_en;
  rob_idx_t [N_ST-1:0]                   st_wr_idx;
  rob_status_t [N_ST-1:0]                st_wr_data;
  rob_status_t [CMT_WIDTH-1:0]           status_rd;
  rob_cmt_t [CMT_WIDTH-1:0]              cmt;

  // ================================================
  // decode payload into the info RAM
  // ================================================
  for (genvar i = 0; i < ALLOC_WIDTH; i++) begin : g_alloc
    assign info_wr_en[i]             = alloc_valid[i] && alloc_ready;
    assign info_wr_idx[i]            = alloc_idx[i][IDX_W-1:0];
    assign info_wr_data[i].pc        = alloc_pc[i];
    assign info_wr_data[i].dest      = alloc_dest[i];
    assign info_wr_data[i].is_branch = alloc_is_branch[i];
    assign info_wr_data[i].is_store  = alloc_is_store[i];
  end

  for (genvar i = 0; i < CMT_WIDTH; i++) begin : g_cmt
    assign cmt_valid[i]  = cmt[i].valid;
    assign cmt_pc[i]     = cmt[i].pc;
    assign cmt_dest[i]   = cmt[i].dest;
    assign cmt_result[i] = cmt[i].result;
  end

  rob_ptr_ctrl #(.DEPTH(DEPTH)) u_ptr (
    .clk         (clk),
    .rst_n       (rst_n),
    .alloc_valid (alloc_valid),
    .alloc_ready (alloc_ready),
    .alloc_idx   (alloc_idx),
    .head_if     (head_if.ptr)
  );

  rob_wb_merge u_merge (
    .alloc_valid     (alloc_valid),
    .alloc_excp      (alloc_excp),
    .alloc_ok        (alloc_ready),
    .alloc_idx       (alloc_idx),
    .alu_wb_valid    (alu_wb_valid),
    .alu_wb_idx      (alu_wb_idx),
    .alu_wb_result   (alu_wb_result),
    .alu_wb_redirect (alu_wb_redirect),
    .alu_wb_target   (alu_wb_target),
    .mem_wb_valid    (mem_wb_valid),
    .mem_wb_idx      (mem_wb_idx),
    .mem_wb_result   (mem_wb_result),
    .mem_wb_excp     (mem_wb_excp),
    .mem_wb_is_store (mem_wb_is_store),
    .mem_wb_ready    (mem_wb_ready),
    .head_if         (head_if.wb),
    .st_wr_en        (st_wr_en),
    .st_wr_idx       (st_wr_idx),
    .st_wr_data      (st_wr_data)
  );

  // static fields, written by decode only
  rob_entry_ram #(.DEPTH(DEPTH), .N_WR(ALLOC_WIDTH), .entry_t(rob_info_t)) u_info_ram (
    .clk     (clk),
    .wr_en   (info_wr_en),
    .wr_idx  (info_wr_idx),
    .wr_data (info_wr_data),
    .rd_head (head_if.head[IDX_W-1:0]),
    .rd_data (info_rd)
  );

  // status fields, allocation clears plus three writebacks
  rob_entry_ram #(.DEPTH(DEPTH), .N_WR(N_ST), .entry_t(rob_status_t)) u_status_ram (
    .clk     (clk),
    .wr_en   (st_wr_en),
    .wr_idx  (st_wr_idx),
    .wr_data (st_wr_data),
    .rd_head (head_if.head[IDX_W-1:0]),
    .rd_data (status_rd)
  );

  rob_commit_fsm #(.EXC_VECTOR(EXC_VECTOR)) u_commit (
    .clk          (clk),
    .rst_n        (rst_n),
    .info         (info_rd),
    .status       (status_rd),
    .head_if      (head_if.cmt),
    .cmt          (cmt),
    .flush        (flush),
    .flush_target (flush_target)
  );

endmodule

//--- sim/rob_assert.sv
// concurrent assertions on the reorder buffer top level, bound into rob_top
`timescale 1ns/100ps

module rob_assert_props (
  input logic       clk,
  input logic       rst_n,
  input logic [1:0] cmt_valid,
  input logic       flush,
  input logic       alloc_ready
);

  // ==================================================
  // flush behavior
  // ==================================================
  // flush strobe lasts one cycle only
  a_flush_one_cycle : assert property (@(posedge clk) disable iff (!rst_n)
    flush |=> !flush)
    else $error("flush held high for more than one cycle");

  a_no_commit_in_flush : assert property (@(posedge clk) disable iff (!rst_n)
    flush |-> (cmt_valid == 2'b00))
    else $error("commit valid while flushing");

  a_no_alloc_in_flush : assert property (@(posedge clk) disable iff (!rst_n)
    flush |-> !alloc_ready)
    else $error("alloc_ready high while flushing");

  // ==================================================
  // commit order
  // ==================================================
  a_slot1_needs_slot0 : assert property (@(posedge clk) disable iff (!rst_n)
    cmt_valid[1] |-> cmt_valid[0])
    else $error("commit slot 1 valid without slot 0");

endmodule

bind rob_top rob_assert_props u_assert (
  .clk         (clk),
  .rst_n       (rst_n),
  .cmt_valid   (cmt_valid),
  .flush       (flush),
  .alloc_ready (alloc_ready)
);

//--- sim/rob_tb.sv
// reorder buffer testbench with stimulus, reference model, compare tasks and watchdog
`timescale 1ns/100ps

module rob_tb;
  import rob_cfg_pkg::*;
  import rob_entry_pkg::*;

  localparam int          STEPS   = 90;
  localparam logic [31:0] EXC_VEC = EXC_VECTOR_DEFAULT;

  typedef rob_cmt_t [1:0] cmt_pair_t;

  // planned attributes plus the model's view of the entry
  typedef struct {
    logic [31:0] pc;
    logic [4:0]  dest;
    logic        br;
    logic        st;
    logic        mem;
    logic        dexc;
    logic        mexc;
    logic        redir;
    logic [31:0] target;
    logic [31:0] result;
    rob_ptr_t    ptr;
    logic        done;
    logic        e;
    logic        r;
  } instr_t;

  logic                   clk;
  logic                   rst_n;
  logic [1:0]             alloc_valid;
  logic [1:0][31:0]       alloc_pc;
  logic [1:0][4:0]        alloc_dest;
  logic [1:0]             alloc_is_branch;
  logic [1:0]             alloc_is_store;
  logic [1:0]             alloc_excp;
  logic                   alloc_ready;
  rob_ptr_t [1:0]         alloc_idx;
  logic [1:0]             alu_wb_valid;
  rob_ptr_t [1:0]         alu_wb_idx;
  logic [1:0][31:0]       alu_wb_result;
  logic [1:0]             alu_wb_redirect;
  logic [1:0][31:0]       alu_wb_target;
  logic                   mem_wb_valid;
  rob_ptr_t               mem_wb_idx;
  logic [31:0]            mem_wb_result;
  logic                   mem_wb_excp;
  logic                   mem_wb_is_store;
  logic                   mem_wb_ready;
  logic [1:0]             cmt_valid;
  logic [1:0][31:0]       cmt_pc;
  logic [1:0][4:0]        cmt_dest;
  logic [1:0][31:0]       cmt_result;
  logic                   flush;
  logic [31:0]            flush_target;

  instr_t      prog[$];
  instr_t      robq[$];
  rob_ptr_t    mhead;
  rob_ptr_t    mtail;
  logic        fl_now;
  logic [31:0] fl_tgt;
  logic        wb_en;
  logic        running;
  int          n_checks;
  int          n_err;

  rob_top #(.DEPTH(8), .EXC_VECTOR(EXC_VEC)) dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ==================================================
  // compare tasks
  // ==================================================
  task automatic slot_compare(input string what, input rob_cmt_t got, input rob_cmt_t exp);
    n_checks++;
    if (got.valid !== exp.valid ||
        (exp.valid && (got.pc !== exp.pc || got.dest !== exp.dest ||
                       got.result !== exp.result))) begin
      n_err++;
      $display("ERR %0t %s got v%0b pc %h rd %0d res %h, expected v%0b pc %h rd %0d res %h",
               $time, what, got.valid, got.pc, got.dest, got.result,
               exp.valid, exp.pc, exp.dest, exp.result);
    end
  endtask

  task automatic ptr_compare(input string what, input rob_ptr_t got, input rob_ptr_t exp);
    n_checks++;
    if (got !== exp) begin
      n_err++;
      $display("ERR %0t %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic flush_compare(input logic got, input logic [31:0] got_t,
                               input logic exp, input logic [31:0] exp_t);
    n_checks++;
    if (got !== exp || (exp && got_t !== exp_t)) begin
      n_err++;
      $display("ERR %0t flush got %0b/%h, expected %0b/%h", $time, got, got_t, exp, exp_t);
    end
  endtask

  task automatic bit_compare(input string what, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_err++;
      $display("ERR %0t %s got %0b, expected %0b", $time, what, got, exp);
    end
  endtask

  // ==================================================
  // reference model
  // ==================================================
  function automatic cmt_pair_t ref_commit();
    cmt_pair_t r;
    logic      k0;
    logic      k1;
    r = '0;
    if (fl_now || robq.size() == 0 || !robq[0].done) begin
      return r;
    end
    r[0] = '{1'b1, robq[0].pc, robq[0].dest, robq[0].result};
    if (robq.size() < 2) begin
      return r;
    end
    k0 = robq[0].e || robq[0].r;
    k1 = robq[1].e || robq[1].r;
    if (robq[1].done && !robq[0].br && !k0 && !k1) begin
      r[1] = '{1'b1, robq[1].pc, robq[1].dest, robq[1].result};
    end
    return r;
  endfunction

  function automatic int find_entry(input rob_ptr_t p);
    for (int j = 0; j < robq.size(); j++) begin
      if (robq[j].ptr == p) begin
        return j;
      end
    end
    return -1;
  endfunction

  // check outputs mid cycle, then apply what the next edge does
  always @(negedge clk) begin
    cmt_pair_t exp;
    rob_cmt_t  got;
    logic      rdy;
    logic      mrdy;
    logic      kill;
    int        j;
    instr_t    it;
    if (running) begin
      exp = ref_commit();
      for (int i = 0; i < 2; i++) begin
        got = '{cmt_valid[i], cmt_pc[i], cmt_dest[i], cmt_result[i]};
        slot_compare($sformatf("commit slot %0d", i), got, exp[i]);
      end
      flush_compare(flush, flush_target, fl_now, fl_tgt);
      rdy = !fl_now && robq.size() <= 6;
      bit_compare("alloc_ready", alloc_ready, rdy);
      ptr_compare("alloc_idx0", alloc_idx[0], mtail);
      ptr_compare("alloc_idx1", alloc_idx[1], mtail + 1'b1);
      mrdy = !mem_wb_is_store || mem_wb_idx == mhead;
      if (mem_wb_valid) begin
        bit_compare("mem_wb_ready", mem_wb_ready, mrdy);
      end
      if (fl_now) begin
        robq.delete();
        mhead  = '0;
        mtail  = '0;
        fl_now = 1'b0;
      end else begin
        kill = exp[0].valid && (robq[0].e || robq[0].r);
        if (kill) begin
          fl_tgt = robq[0].e ? EXC_VEC : robq[0].target;
        end
        for (int i = 0; i < 2; i++) begin
          if (exp[i].valid) begin
            void'(robq.pop_front());
            mhead = mhead + 1'b1;
          end
        end
        for (int a = 0; a < 2; a++) begin
          j = alu_wb_valid[a] ? find_entry(alu_wb_idx[a]) : -1;
          if (j >= 0) begin
            robq[j].done   = 1'b1;
            robq[j].result = alu_wb_result[a];
            robq[j].r      = alu_wb_redirect[a];
            robq[j].target = alu_wb_target[a];
          end
        end
        j = (mem_wb_valid && mrdy) ? find_entry(mem_wb_idx) : -1;
        if (j >= 0) begin
          robq[j].done   = 1'b1;
          robq[j].result = mem_wb_result;
          robq[j].e      = robq[j].e || mem_wb_excp;
        end
        for (int i = 0; i < 2; i++) begin
          if (rdy && alloc_valid[i]) begin
            it        = prog.pop_front();
            it.ptr    = mtail;
            it.done   = it.dexc;
            it.e      = it.dexc;
            it.r      = 1'b0;
            it.result = '0;
            robq.push_back(it);
            mtail = mtail + 1'b1;
          end
        end
        fl_now = kill;
      end
    end
  end

  // ==================================================
  // stimulus
  // ==================================================
  task automatic drive_cycle();
    int alu_c[$];
    int mem_c[$];
    int k;
    alloc_valid  = '0;
    alu_wb_valid = '0;
    mem_wb_valid = 1'b0;
    for (int i = 0; i < 2; i++) begin
      if (i < prog.size() && (i == 0 ? ($urandom % 4 != 0) : alloc_valid[0] && $urandom % 2)) begin
        alloc_valid[i]     = 1'b1;
        alloc_pc[i]        = prog[i].pc;
        alloc_dest[i]      = prog[i].dest;
        alloc_is_branch[i] = prog[i].br;
        alloc_is_store[i]  = prog[i].st;
        alloc_excp[i]      = prog[i].dexc;
      end
    end
    if (!wb_en) begin
      return;
    end
    foreach (robq[j]) begin
      if (!robq[j].done && robq[j].mem) begin
        mem_c.push_back(j);
      end else if (!robq[j].done) begin
        alu_c.push_back(j);
      end
    end
    for (int a = 0; a < 2; a++) begin
      if (alu_c.size() > 0 && $urandom % 2) begin
        k = $urandom % alu_c.size();
        alu_wb_valid[a]    = 1'b1;
        alu_wb_idx[a]      = robq[alu_c[k]].ptr;
        alu_wb_result[a]   = $urandom;
        alu_wb_redirect[a] = robq[alu_c[k]].redir;
        alu_wb_target[a]   = robq[alu_c[k]].target;
        alu_c.delete(k);
      end
    end
    if (mem_c.size() > 0 && $urandom % 2) begin
      k = mem_c[$urandom % mem_c.size()];
      mem_wb_valid    = 1'b1;
      mem_wb_idx      = robq[k].ptr;
      mem_wb_result   = $urandom;
      mem_wb_excp     = robq[k].mexc;
      mem_wb_is_store = robq[k].st;
    end
  endtask

  task automatic add_instr(input logic br, input logic st, input logic mem,
                           input logic dexc, input logic mexc, input logic redir);
    instr_t it;
    it        = '{default: '0};
    it.pc     = {30'($urandom), 2'b00};
    it.dest   = 5'($urandom);
    it.br     = br;
    it.st     = st;
    it.mem    = mem;
    it.dexc   = dexc;
    it.mexc   = mexc;
    it.redir  = redir;
    it.target = {30'($urandom), 2'b00};
    prog.push_back(it);
  endtask

  task automatic run_test(input string name, input int hold);
    int err0;
    err0  = n_err;
    wb_en = 1'b0;
    repeat (hold) @(posedge clk);
    wb_en = 1'b1;
    do begin
      @(posedge clk);
    end while (prog.size() > 0 || robq.size() > 0 || fl_now);
    $display("test %s finished, %0d errors", name, n_err - err0);
  endtask

  always @(posedge clk) begin
    if (running) begin
      #2 drive_cycle();
    end
  end

  initial begin
    #(STEPS * 50 * 40);
    $display("watchdog expired before the tests completed");
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    logic st;
    void'($urandom(32'hb304));
    rst_n = 1'b0;
    {alloc_valid, alloc_pc, alloc_dest, alloc_is_branch, alloc_is_store, alloc_excp} = '0;
    {alu_wb_valid, alu_wb_idx, alu_wb_result, alu_wb_redirect, alu_wb_target} = '0;
    {mem_wb_valid, mem_wb_idx, mem_wb_result, mem_wb_excp, mem_wb_is_store} = '0;
    {mhead, mtail, fl_now, fl_tgt, wb_en, running, n_checks, n_err} = '0;
    repeat (3) @(posedge clk);
    #2 rst_n = 1'b1;
    running = 1'b1;

    for (int i = 0; i < 40; i++) begin
      st = ($urandom % 5 == 0);
      add_instr(1'b0, st, st || ($urandom % 3 == 0), 1'b0, 1'b0, 1'b0);
    end
    run_test("in_order", 0);
    repeat (12) add_instr(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    run_test("full_buffer", 30);
    for (int i = 0; i < 10; i++) begin
      add_instr(i % 3 != 2, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    end
    run_test("branch_pairs", 8);
    for (int i = 0; i < 8; i++) begin
      add_instr(i == 3, 1'b0, 1'b0, 1'b0, 1'b0, i == 3);
    end
    run_test("redirect", 0);
    for (int i = 0; i < 12; i++) begin
      add_instr(1'b0, 1'b0, i == 8, i == 1, i == 8, 1'b0);
    end
    run_test("exceptions", 0);
    for (int i = 0; i < 8; i++) begin
      add_instr(1'b0, i % 2 == 1, 1'b1, 1'b0, 1'b0, 1'b0);
    end
    run_test("store_order", 0);

    running = 1'b0;
    $display("checks %0d, errors %0d", n_checks, n_err);
    if (n_err == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- tb.f
logic/rob_cfg_pkg.sv
logic/rob_entry_pkg.sv
logic/rob_head_if.sv
logic/rob_ptr_ctrl.sv
logic/rob_entry_ram.sv
logic/rob_wb_merge.sv
logic/rob_commit_fsm.sv
logic/rob_top.sv
sim/rob_assert.sv
sim/rob_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the reorder buffer testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rob_tb -f tb.f -o rob_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out="$(./obj_dir/rob_sim)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx ">>> PASS" <<< "$out"; then
  exit 0
fi
exit 1
